// File: verilog/ruche_pkg.sv
// ruche row package: coordinate and payload widths, packet and link structs, grant enum
package ruche_pkg;

  // node coordinate along the row, up to 16 nodes
  localparam int cord_width_c = 4;

  // packet payload width
  localparam int payload_width_c = 16;

  // packet carried on every link
  typedef struct packed {
    logic [cord_width_c-1:0]    dest_x;
    logic [payload_width_c-1:0] payload;
  } packet_s;

  // forward half of a link, ready travels back as its own bit
  typedef struct packed {
    logic    v;
    packet_s pkt;
  } link_s;

  // last winner of a two-input round-robin arbiter
  typedef enum logic {
    GNT_A,
    GNT_B
  } grant_e;

endpackage

// File: verilog/edge_ingress.sv
// west-edge ingress buffer with out-of-range drop and saturating drop counter
`timescale 1ns/1ns

module edge_ingress #(
  parameter int num_nodes_p = 8
) (
  input  logic                clk_i,
  input  logic                rst_i,
  input  ruche_pkg::link_s    in_link_i,
  output logic                in_ready_o,
  output ruche_pkg::link_s    out_link_o,
  input  logic                out_ready_i,
  output logic [15:0]         drop_count_o
);

  logic               buf_v_q;
  ruche_pkg::packet_s buf_pkt_q;
  logic               accept;
  logic               in_range;

  // one entry, refilled in the same cycle it drains
  assign in_ready_o = ~buf_v_q | out_ready_i;
  assign accept     = in_link_i.v & in_ready_o;
  assign in_range   = int'(in_link_i.pkt.dest_x) < num_nodes_p;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      buf_v_q <= 1'b0;
    end else if (accept && in_range) begin
      buf_v_q <= 1'b1;
    end else if (out_ready_i) begin
      buf_v_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (accept && in_range) begin
      buf_pkt_q <= in_link_i.pkt;
    end
  end

  // out-of-range packets are consumed here and only counted
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      drop_count_o <= '0;
    end else if (accept && !in_range && drop_count_o != 16'hffff) begin
      drop_count_o <= drop_count_o + 16'd1;
    end
  end

  assign out_link_o = '{v: buf_v_q, pkt: buf_pkt_q};

endmodule

// File: verilog/ruche_node.sv
// single ruche routing node: route decode, three round-robin arbiters and output registers
`timescale 1ns/1ns

module ruche_node #(
  parameter int ruche_factor_p = 3
) (
  input  logic                              clk_i,
  input  logic                              rst_i,
  input  logic [ruche_pkg::cord_width_c-1:0] my_x_i,

  input  ruche_pkg::link_s                  local_link_i,
  output logic                              local_ready_o,
  input  ruche_pkg::link_s                  ruche_link_i,
  output logic                              ruche_ready_o,

  output ruche_pkg::link_s                  local_link_o,
  input  logic                              local_ready_i,
  output ruche_pkg::link_s                  ruche_link_o,
  input  logic                              ruche_ready_i,
  output ruche_pkg::link_s                  eject_link_o,
  input  logic                              eject_ready_i
);

  // output order in the request vectors: local, ruche, eject
  localparam int num_outs_lp = 3;

  ruche_pkg::link_s [1:0]            in_link;
  logic [1:0][num_outs_lp-1:0]       req;
  logic [num_outs_lp-1:0]            out_ready;
  ruche_pkg::link_s [num_outs_lp-1:0] out_link;
  logic [num_outs_lp-1:0]            gnt_a;
  logic [num_outs_lp-1:0]            gnt_b;

  // one-hot route for a packet seen at this node
  function automatic logic [num_outs_lp-1:0] route_f(
    input logic [ruche_pkg::cord_width_c-1:0] dest_x,
    input logic [ruche_pkg::cord_width_c-1:0] my_x
  );
    logic [num_outs_lp-1:0] sel;
    if (dest_x == my_x) begin
      sel = 3'b100;
    end else if (int'(dest_x) >= int'(my_x) + ruche_factor_p) begin
      // far enough to skip ahead on the ruche link
      sel = 3'b010;
    end else begin
      sel = 3'b001;
    end
    return sel;
  endfunction

  // requester A is the local input, requester B the ruche input
  assign in_link = {ruche_link_i, local_link_i};

  for (genvar i = 0; i < 2; i++) begin : g_route
    assign req[i] = route_f(in_link[i].pkt.dest_x, my_x_i);
  end

  assign out_ready = {eject_ready_i, ruche_ready_i, local_ready_i};

  for (genvar o = 0; o < num_outs_lp; o++) begin : g_out
    logic               req_a;
    logic               req_b;
    logic               pick_b;
    logic               free;
    logic               out_v_q;
    ruche_pkg::packet_s out_pkt_q;
    ruche_pkg::grant_e  last_q;

    assign req_a = in_link[0].v & req[0][o];
    assign req_b = in_link[1].v & req[1][o];

    // B wins alone, or on a tie when A won last time
    assign pick_b = req_b & (~req_a | (last_q == ruche_pkg::GNT_A));

    // register takes a new packet when empty or draining
    assign free = ~out_v_q | out_ready[o];

    assign gnt_a[o] = free & req_a & ~pick_b;
    assign gnt_b[o] = free & pick_b;

    always_ff @(posedge clk_i) begin
      if (rst_i) begin
        out_v_q <= 1'b0;
        last_q  <= ruche_pkg::GNT_A;
      end else if (free) begin
        out_v_q <= req_a | req_b;
        if (req_a || req_b) begin
          last_q <= pick_b ? ruche_pkg::GNT_B : ruche_pkg::GNT_A;
        end
      end
    end

    always_ff @(posedge clk_i) begin
      if (free && (req_a || req_b)) begin
        out_pkt_q <= pick_b ? in_link[1].pkt : in_link[0].pkt;
      end
    end

    assign out_link[o] = '{v: out_v_q, pkt: out_pkt_q};
  end

  assign {eject_link_o, ruche_link_o, local_link_o} = out_link;

  // each input asks for exactly one output, so any grant means it moved
  assign local_ready_o = |gnt_a;
  assign ruche_ready_o = |gnt_b;

endmodule

// File: verilog/node_array.sv
// row of ruche nodes with local and ruche wiring, edge tie-offs and node coordinates
`timescale 1ns/1ns

module node_array #(
  parameter int num_nodes_p    = 8,
  parameter int ruche_factor_p = 3
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  ruche_pkg::link_s                   west_link_i,
  output logic                               west_ready_o,
  output ruche_pkg::link_s [num_nodes_p-1:0] eject_link_o,
  input  logic [num_nodes_p-1:0]             eject_ready_i
);

  // inputs and their readies seen by node x
  ruche_pkg::link_s [num_nodes_p-1:0] local_li;
  ruche_pkg::link_s [num_nodes_p-1:0] ruche_li;
  logic [num_nodes_p-1:0]             local_ready_lo;
  logic [num_nodes_p-1:0]             ruche_ready_lo;

  // outputs of node x and the readies returned to them
  ruche_pkg::link_s [num_nodes_p-1:0] local_lo;
  ruche_pkg::link_s [num_nodes_p-1:0] ruche_lo;
  logic [num_nodes_p-1:0]             local_ready_li;
  logic [num_nodes_p-1:0]             ruche_ready_li;

  for (genvar x = 0; x < num_nodes_p; x++) begin : g_node
    ruche_node #(
      .ruche_factor_p(ruche_factor_p)
    ) node (
      .clk_i         (clk_i),
      .rst_i         (rst_i),
      .my_x_i        ((ruche_pkg::cord_width_c)'(x)),
      .local_link_i  (local_li[x]),
      .local_ready_o (local_ready_lo[x]),
      .ruche_link_i  (ruche_li[x]),
      .ruche_ready_o (ruche_ready_lo[x]),
      .local_link_o  (local_lo[x]),
      .local_ready_i (local_ready_li[x]),
      .ruche_link_o  (ruche_lo[x]),
      .ruche_ready_i (ruche_ready_li[x]),
      .eject_link_o  (eject_link_o[x]),
      .eject_ready_i (eject_ready_i[x])
    );

    // local hop to the east neighbour, east end always ready
    if (x < num_nodes_p-1) begin : g_local
      assign local_li[x+1]     = local_lo[x];
      assign local_ready_li[x] = local_ready_lo[x+1];
    end else begin : g_local_end
      assign local_ready_li[x] = 1'b1;
    end

    // ruche hop skips ruche_factor_p nodes
    if (x + ruche_factor_p < num_nodes_p) begin : g_ruche
      assign ruche_li[x+ruche_factor_p] = ruche_lo[x];
      assign ruche_ready_li[x]          = ruche_ready_lo[x+ruche_factor_p];
    end else begin : g_ruche_end
      assign ruche_ready_li[x] = 1'b1;
    end

    // nothing feeds the first ruche inputs
    if (x < ruche_factor_p) begin : g_ruche_tie
      assign ruche_li[x] = '0;
    end
  end

  assign local_li[0]  = west_link_i;
  assign west_ready_o = local_ready_lo[0];

endmodule

// File: verilog/eject_merge.sv
// egress merge: round-robin arbiter over all eject ports feeding one output register
`timescale 1ns/1ns

module eject_merge #(
  parameter int num_nodes_p = 8
) (
  input  logic                               clk_i,
  input  logic                               rst_i,
  input  ruche_pkg::link_s [num_nodes_p-1:0] eject_link_i,
  output logic [num_nodes_p-1:0]             eject_ready_o,
  output ruche_pkg::link_s                   out_link_o,
  input  logic                               out_ready_i
);

  localparam int ptr_width_lp = $clog2(num_nodes_p);

  logic [ptr_width_lp-1:0] last_q;
  logic [ptr_width_lp-1:0] pick;
  logic                    found;
  logic                    free;
  logic                    out_v_q;
  ruche_pkg::packet_s      out_pkt_q;

  assign free = ~out_v_q | out_ready_i;

  // search starts one past the last winner and wraps
  always_comb begin
    int idx;
    pick  = last_q;
    found = 1'b0;
    for (int i = 1; i <= num_nodes_p; i++) begin
      idx = (int'(last_q) + i) % num_nodes_p;
      if (!found && eject_link_i[idx].v) begin
        pick  = (ptr_width_lp)'(idx);
        found = 1'b1;
      end
    end
  end

  always_comb begin
    eject_ready_o = '0;
    if (found && free) begin
      eject_ready_o[pick] = 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      out_v_q <= 1'b0;
      last_q  <= '0;
    end else if (free) begin
      out_v_q <= found;
      if (found) begin
        last_q <= pick;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (free && found) begin
      out_pkt_q <= eject_link_i[pick].pkt;
    end
  end

  assign out_link_o = '{v: out_v_q, pkt: out_pkt_q};

endmodule

// File: verilog/ruche_row_top.sv
// ruche row top level: ingress buffer, node row and eject merge
`timescale 1ns/1ns

module ruche_row_top #(
  parameter int num_nodes_p    = 8,
  parameter int ruche_factor_p = 3
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  ruche_pkg::link_s in_link_i,
  output logic             in_ready_o,
  output ruche_pkg::link_s out_link_o,
  input  logic             out_ready_i,
  output logic [15:0]      drop_count_o
);

  ruche_pkg::link_s                   west_link;
  logic                               west_ready;
  ruche_pkg::link_s [num_nodes_p-1:0] eject_link;
  logic [num_nodes_p-1:0]             eject_ready;

  edge_ingress #(
    .num_nodes_p(num_nodes_p)
  ) i_ingress (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .in_link_i    (in_link_i),
    .in_ready_o   (in_ready_o),
    .out_link_o   (west_link),
    .out_ready_i  (west_ready),
    .drop_count_o (drop_count_o)
  );

  node_array #(
    .num_nodes_p    (num_nodes_p),
    .ruche_factor_p (ruche_factor_p)
  ) i_row (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .west_link_i   (west_link),
    .west_ready_o  (west_ready),
    .eject_link_o  (eject_link),
    .eject_ready_i (eject_ready)
  );

  eject_merge #(
    .num_nodes_p(num_nodes_p)
  ) i_egress (
    .clk_i         (clk_i),
    .rst_i         (rst_i),
    .eject_link_i  (eject_link),
    .eject_ready_o (eject_ready),
    .out_link_o    (out_link_o),
    .out_ready_i   (out_ready_i)
  );

endmodule

// File: testbench/tb_row_checker.sv
// output checker: per-destination scoreboards, drop count check and per-test summary
`timescale 1ns/1ns

module tb_row_checker #(
  parameter int num_nodes_p = 8
) (
  input  logic             clk_i,
  input  logic             rst_i,
  input  ruche_pkg::link_s out_link_i,
  input  logic             out_ready_i,
  input  logic [15:0]      drop_count_i,
  input  logic             stim_done_i,
  output logic             done_o,
  output int               err_count_o
);

  localparam int depth_lp      = 64;
  localparam int wait_limit_lp = 20000;

  // expected payloads per destination, popped at head
  logic [15:0] exp_mem [16][depth_lp];
  int          head [16];
  int          tail [16];
  int          got [16];
  int          exp_drops;
  // 1 reset, 2 payload, 3 drops, 4 order, 5 drain
  int          errs [1:5];

  function automatic int pending();
    int n;
    n = 0;
    for (int i = 0; i < 16; i++) begin
      n += tail[i] - head[i];
    end
    return n;
  endfunction

  // consume the rest of a line that holds no packet
  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != "\n" && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  task automatic load_golden();
    int fd;
    int fields;
    int dest;
    int payload;
    int dropped;
    int d;
    fd = $fopen("testbench/ruche_row_golden.txt", "r");
    if (fd == 0) begin
      $display("checker cannot open the golden file");
      errs[5]++;
    end else begin
      while (!$feof(fd)) begin
        fields = $fscanf(fd, "%h %h %h", dest, payload, dropped);
        if (fields == 3) begin
          d = dest & 15;
          if (dropped != 0) begin
            exp_drops++;
          end else if (tail[d] < depth_lp) begin
            exp_mem[d][tail[d]] = payload[15:0];
            tail[d]++;
          end
        end else begin
          skip_line(fd);
        end
      end
      $fclose(fd);
    end
  endtask

  task automatic check_packet(input ruche_pkg::packet_s pkt);
    int   d;
    logic later;
    d     = int'(pkt.dest_x);
    later = 1'b0;
    if (d >= num_nodes_p) begin
      $display("a packet to out-of-range node %0d left the row", d);
      errs[3]++;
    end else if (head[d] == tail[d]) begin
      $display("an extra packet to node %0d left the row, payload %h", d, pkt.payload);
      errs[5]++;
    end else begin
      if (pkt.payload !== exp_mem[d][head[d]]) begin
        $display("ERR out_link_o.pkt.payload node %0d expected %h actual %h",
                 d, exp_mem[d][head[d]], pkt.payload);
        // a payload still queued behind the head means reordering
        for (int k = head[d] + 1; k < tail[d]; k++) begin
          if (exp_mem[d][k] === pkt.payload) begin
            later = 1'b1;
          end
        end
        if (later) begin
          errs[4]++;
        end else begin
          errs[2]++;
        end
      end else begin
        got[d]++;
      end
      head[d]++;
    end
  endtask

  task automatic report_test(input int num, input string name);
    $display("test %0d %s: %s", num, name, (errs[num] == 0) ? "pass" : "fail");
  endtask

  // v and ready seen together at the falling edge mean a transfer on the next rising edge
  always @(negedge clk_i) begin
    if (!rst_i && out_link_i.v && out_ready_i) begin
      check_packet(out_link_i.pkt);
    end
  end

  initial begin
    int waited;
    int passed;
    done_o      = 1'b0;
    err_count_o = 0;
    exp_drops   = 0;
    passed      = 0;
    for (int i = 0; i < 16; i++) begin
      head[i] = 0;
      tail[i] = 0;
      got[i]  = 0;
    end
    for (int t = 1; t <= 5; t++) begin
      errs[t] = 0;
    end
    load_golden();
    waited = 0;
    @(negedge clk_i);
    while (rst_i && waited < wait_limit_lp) begin
      @(negedge clk_i);
      waited++;
    end
    if (rst_i) begin
      $display("timeout: reset was never released");
      errs[1]++;
    end
    if (out_link_i.v !== 1'b0) begin
      $display("ERR out_link_o.v expected %h actual %h", 1'b0, out_link_i.v);
      errs[1]++;
    end
    if (drop_count_i !== 16'h0) begin
      $display("ERR drop_count_o expected %h actual %h", 16'h0, drop_count_i);
      errs[1]++;
    end
    waited = 0;
    while (!stim_done_i && waited < wait_limit_lp) begin
      @(negedge clk_i);
      waited++;
    end
    if (!stim_done_i) begin
      $display("timeout: the stimulus never finished");
      errs[5]++;
    end
    waited = 0;
    while (pending() != 0 && waited < wait_limit_lp) begin
      @(negedge clk_i);
      waited++;
    end
    // late duplicates and the last drop count update
    repeat (20) @(negedge clk_i);
    if (pending() != 0) begin
      $display("timeout: %0d expected packets never left the row", pending());
      errs[5]++;
    end
    if (drop_count_i !== exp_drops[15:0]) begin
      $display("ERR drop_count_o expected %h actual %h", exp_drops[15:0], drop_count_i);
      errs[3]++;
    end
    for (int i = 0; i < num_nodes_p; i++) begin
      if (got[i] == 0) begin
        $display("no packet to node %0d arrived with a correct payload", i);
        errs[2]++;
      end
    end
    report_test(1, "reset state");
    report_test(2, "delivery to every node");
    report_test(3, "out-of-range drops");
    report_test(4, "per-destination order");
    report_test(5, "drain under back-pressure");
    for (int t = 1; t <= 5; t++) begin
      err_count_o += errs[t];
      passed      += (errs[t] == 0) ? 1 : 0;
    end
    $display("summary: 5 tests, %0d passed, %0d failed, %0d errors",
             passed, 5 - passed, err_count_o);
    done_o = 1'b1;
  end

endmodule

// File: testbench/tb_ruche_row.sv
// testbench top: clock, reset, golden-file stimulus, random output back-pressure and verdict
`timescale 1ns/1ns

module tb_ruche_row;

  localparam int wait_limit_lp = 2000;

  logic             clk_i;
  logic             rst_i;
  ruche_pkg::link_s in_link_i;
  logic             in_ready_o;
  ruche_pkg::link_s out_link_o;
  logic             out_ready_i;
  logic [15:0]      drop_count_o;
  logic             stim_done;
  logic             chk_done;
  int               chk_errors;
  int               tb_errors;
  logic [31:0]      lfsr;

  ruche_row_top #(
    .num_nodes_p    (8),
    .ruche_factor_p (3)
  ) i_dut (.*);

  tb_row_checker #(
    .num_nodes_p(8)
  ) i_checker (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .out_link_i   (out_link_o),
    .out_ready_i  (out_ready_i),
    .drop_count_i (drop_count_o),
    .stim_done_i  (stim_done),
    .done_o       (chk_done),
    .err_count_o  (chk_errors)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  // galois lfsr, one step per bit taken
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
  endfunction

  // output ready is low only when both drawn bits are zero
  initial begin
    logic first_bit;
    lfsr        = 32'h9649;
    out_ready_i = 1'b0;
    forever begin
      @(posedge clk_i);
      #1;
      first_bit   = lfsr[0];
      lfsr        = lfsr_step(lfsr);
      out_ready_i = first_bit | lfsr[0];
      lfsr        = lfsr_step(lfsr);
    end
  end

  // consume the rest of a line that holds no packet
  task automatic skip_line(input int fd);
    int c;
    c = $fgetc(fd);
    while (c != "\n" && c != -1) begin
      c = $fgetc(fd);
    end
  endtask

  // hold one packet on the input until the ingress takes it
  task automatic send_packet(input logic [3:0] dest, input logic [15:0] payload);
    int waited;
    waited    = 0;
    in_link_i = {1'b1, dest, payload};
    @(negedge clk_i);
    while (!in_ready_o && waited < wait_limit_lp) begin
      waited++;
      @(negedge clk_i);
    end
    if (!in_ready_o) begin
      $display("timeout: in_ready_o stayed low for %0d cycles", wait_limit_lp);
      tb_errors++;
    end
    @(posedge clk_i);
    #1;
  endtask

  initial begin
    int fd;
    int fields;
    int waited;
    int dest;
    int payload;
    int dropped;
    rst_i     = 1'b1;
    in_link_i = '0;
    stim_done = 1'b0;
    tb_errors = 0;
    waited    = 0;
    repeat (5) @(posedge clk_i);
    #1;
    rst_i = 1'b0;
    fd = $fopen("testbench/ruche_row_golden.txt", "r");
    if (fd == 0) begin
      $display("cannot open the golden file testbench/ruche_row_golden.txt");
      tb_errors++;
    end else begin
      while (!$feof(fd) && tb_errors == 0) begin
        fields = $fscanf(fd, "%h %h %h", dest, payload, dropped);
        if (fields == 3) begin
          send_packet(dest[3:0], payload[15:0]);
        end else begin
          skip_line(fd);
        end
      end
      $fclose(fd);
    end
    in_link_i = '0;
    stim_done = 1'b1;
    while (!chk_done && waited < 50 * wait_limit_lp) begin
      @(negedge clk_i);
      waited++;
    end
    if (!chk_done) begin
      $display("timeout: the checker did not finish its final checks");
      tb_errors++;
    end
    if (tb_errors == 0 && chk_errors == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

// File: verilog.f
verilog/ruche_pkg.sv
verilog/edge_ingress.sv
verilog/ruche_node.sv
verilog/node_array.sv
verilog/eject_merge.sv
verilog/ruche_row_top.sv
testbench/tb_row_checker.sv
testbench/tb_ruche_row.sv

// File: Bender.yml
package:
  name: ruche_row

sources:
  - verilog/ruche_pkg.sv
  - verilog/edge_ingress.sv
  - verilog/ruche_node.sv
  - verilog/node_array.sv
  - verilog/eject_merge.sv
  - verilog/ruche_row_top.sv
  - target: test
    files:
      - testbench/tb_row_checker.sv
      - testbench/tb_ruche_row.sv

// File: testbench/ruche_row_golden.txt
# columns in hex: dest_x payload dropped
# dropped is 1 where dest_x lies outside the row and the packet must never leave
0 1000 0
1 1101 0
2 1202 0
3 1303 0
4 1404 0
5 1505 0
6 1606 0
7 1707 0
8 dead 1
7 2701 0
2 2201 0
7 2702 0
5 2501 0
f beef 1
7 2703 0
2 2202 0
0 2001 0
7 2704 0
9 0bad 1
3 2301 0
6 2601 0
3 2302 0
c cafe 1
4 2401 0
1 2101 0
4 2402 0
6 2602 0
a 0a0a 1
5 2502 0
7 2705 0
